// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = tb_mempool_system
FILELIST  = files.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== bench/tb_mempool_system.sv ====
/* Testbench for the MemPool system memory side
   Table-driven host traffic, external port model and in-order response scoreboard */
`timescale 1ns/1ps
`include "mempool_consts.svh"

module tb_mempool_system
  import mempool_pkg::*;
();

  localparam int          NUM_ROWS = 25;
  localparam int          TIMEOUT  = 20;
  localparam int          L2_WORDS = `NUM_L2_BANKS * `L2_BANK_WORDS;
  localparam logic [31:0] L2_BASE  = `L2_BASE_ADDR;
  localparam logic [31:0] ROM_BASE = `BOOTROM_BASE_ADDR;
  localparam logic [31:0] PER_BASE = `PERIPH_BASE_ADDR;
  localparam logic [31:0] EXT_KEY  = 32'h5A5A_5A5A;

  typedef struct packed {
    logic [31:0] addr;
    logic        we;
    logic [31:0] wdata;
    logic [3:0]  be;
    logic [31:0] exp;
    logic        chk;
  } row_t;

  // One entry per accepted request that leaves the queue with its rvalid
  typedef struct packed {
    logic [31:0] addr;
    logic        we;
    logic [31:0] wdata;
    logic [31:0] exp;
    logic        chk;
    logic        ext;
    logic [31:0] cyc;  // Expected response cycle for internal targets
  } pend_t;

  logic                  clk_i;
  logic                  rst_n_i;
  mem_req_t              host_req_i;
  logic                  host_gnt_o;
  mem_rsp_t              host_rsp_o;
  mem_req_t              mst_req_o;
  logic                  mst_gnt_i;
  mem_rsp_t              mst_rsp_i;
  logic                  eoc_valid_o;
  logic [`NUM_CORES-1:0] wake_up_o;

  row_t                  stim [NUM_ROWS];
  pend_t                 pend_q [$];
  pend_t                 ent;
  logic [31:0]           l2_model [L2_WORDS];
  logic [`NUM_CORES-1:0] wake_exp;
  logic [31:0]           cyc_cnt = '0;
  logic [31:0]           lcg_state = 32'hf1fe;
  int                    row_idx = 0;

  mempool_system mempool_system_inst (
    .clk_i      (clk_i      ),
    .rst_n_i    (rst_n_i    ),
    .host_req_i (host_req_i ),
    .host_gnt_o (host_gnt_o ),
    .host_rsp_o (host_rsp_o ),
    .mst_req_o  (mst_req_o  ),
    .mst_gnt_i  (mst_gnt_i  ),
    .mst_rsp_i  (mst_rsp_i  ),
    .eoc_valid_o(eoc_valid_o),
    .wake_up_o  (wake_up_o  )
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  always @(posedge clk_i) cyc_cnt <= cyc_cnt + 1;

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic is_l2(input logic [31:0] a);
    return a >= L2_BASE && a < L2_BASE + L2_WORDS * 4;
  endfunction

  function automatic logic is_internal(input logic [31:0] a);
    return is_l2(a) || (a >= PER_BASE && a < `PERIPH_END_ADDR) ||
           (a >= ROM_BASE && a < `BOOTROM_END_ADDR);
  endfunction

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("Simulation FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERR %s: got 0x%h, expected 0x%h", name, got, exp);
      $display("Simulation FAILED");
      $fatal(1);
    end
  endtask

  // Expected data is fixed at accept time and L2 data comes from the scoreboard
  task automatic record_accept();
    pend_t e;
    int    idx;
    e.addr  = host_req_i.addr;
    e.we    = host_req_i.we;
    e.wdata = host_req_i.wdata;
    e.chk   = stim[row_idx].chk;
    e.ext   = !is_internal(host_req_i.addr);
    e.cyc   = cyc_cnt + 1;
    idx     = int'((host_req_i.addr - L2_BASE) >> 2);
    if (is_l2(e.addr)) begin
      e.exp = l2_model[idx];
      for (int i = 0; i < `BE_WIDTH; i++) begin
        if (e.we && host_req_i.be[i]) l2_model[idx][i*8 +: 8] = host_req_i.wdata[i*8 +: 8];
      end
    end else if (e.ext) begin
      e.exp = e.addr ^ EXT_KEY;
    end else begin
      e.exp = stim[row_idx].exp;
    end
    pend_q.push_back(e);
  endtask

  always @(negedge clk_i) begin
    if (rst_n_i) begin
      wake_exp = '0;
      if (host_rsp_o.rvalid) begin
        if (pend_q.size() == 0) report_failure("Response arrived with no request outstanding");
        ent = pend_q.pop_front();
        if (!ent.ext) check_value("host_rsp_o.rvalid cycle", cyc_cnt, ent.cyc);
        if (ent.chk && !ent.we) check_value("host_rsp_o.rdata", host_rsp_o.rdata, ent.exp);
        if (ent.we && ent.addr == PER_BASE + `REG_WAKE_UP) wake_exp = ent.wdata[`NUM_CORES-1:0];
        if (ent.we && ent.addr == PER_BASE + `REG_EOC) begin
          check_value("eoc_valid_o", eoc_valid_o, ent.wdata[0]);
        end
      end
      check_value("wake_up_o", wake_up_o, wake_exp);  // Pulse only in the response cycle
      if (host_req_i.req && host_gnt_o) record_accept();
    end
  end

  // External port model grants after 0-3 cycles and answers 1-4 cycles after the grant
  initial begin
    row_t        cur_row;
    logic [31:0] grant_addr;
    int          gnt_wait;
    int          rsp_wait;
    mst_gnt_i = 1'b0;
    mst_rsp_i = '0;
    forever begin
      @(negedge clk_i);
      if (mst_req_o.req) begin
        cur_row = stim[row_idx];
        check_value("mst_req_o.addr", mst_req_o.addr, cur_row.addr);
        check_value("mst_req_o.we", mst_req_o.we, cur_row.we);
        check_value("mst_req_o.wdata", mst_req_o.wdata, cur_row.wdata);
        check_value("mst_req_o.be", mst_req_o.be, cur_row.be);
        check_value("host_gnt_o", host_gnt_o, 1'b0);
        gnt_wait = int'(lcg_next() >> 16) % 4;
        rsp_wait = 1 + int'(lcg_next() >> 16) % 4;
        repeat (gnt_wait) begin
          @(negedge clk_i);
          check_value("mst_req_o.req", mst_req_o.req, 1'b1);
          check_value("host_gnt_o", host_gnt_o, 1'b0);
        end
        @(posedge clk_i);
        #1;
        mst_gnt_i  = 1'b1;
        grant_addr = mst_req_o.addr;
        @(posedge clk_i);
        #1;
        mst_gnt_i = 1'b0;
        repeat (rsp_wait - 1) begin
          @(posedge clk_i);
          #1;
        end
        mst_rsp_i.rvalid = 1'b1;
        mst_rsp_i.rdata  = grant_addr ^ EXT_KEY;
        @(posedge clk_i);
        #1;
        mst_rsp_i = '0;
      end
    end
  end

  task automatic apply_row(input row_t r);
    int waited;
    waited     = 0;
    host_req_i = '{req: 1'b1, we: r.we, addr: r.addr, wdata: r.wdata, be: r.be};
    @(negedge clk_i);
    while (!host_gnt_o) begin
      waited++;
      if (waited > TIMEOUT) report_failure("Host request was never granted");
      @(negedge clk_i);
    end
    @(posedge clk_i);
    #1;
  endtask

  // Columns are addr, we, wdata, be, expected rdata and check flag
  // L2 and external rows take their expected data from the models
  initial begin
    stim[0]  = '{L2_BASE + 32'h00, 1'b1, 32'h1111_1111, 4'hF, 32'h0, 1'b0};
    stim[1]  = '{L2_BASE + 32'h04, 1'b1, 32'h2222_2222, 4'hF, 32'h0, 1'b0};
    stim[2]  = '{L2_BASE + 32'h08, 1'b1, 32'h3333_3333, 4'hF, 32'h0, 1'b0};
    stim[3]  = '{L2_BASE + 32'h0C, 1'b1, 32'h4444_4444, 4'hF, 32'h0, 1'b0};
    stim[4]  = '{L2_BASE + 32'h04, 1'b1, 32'hAABB_CCDD, 4'h5, 32'h0, 1'b0};
    stim[5]  = '{L2_BASE + 32'h00, 1'b0, 32'h0, 4'hF, 32'h0, 1'b1};
    stim[6]  = '{L2_BASE + 32'h04, 1'b0, 32'h0, 4'hF, 32'h0, 1'b1};
    stim[7]  = '{L2_BASE + 32'h08, 1'b0, 32'h0, 4'hF, 32'h0, 1'b1};
    stim[8]  = '{L2_BASE + 32'h0C, 1'b0, 32'h0, 4'hF, 32'h0, 1'b1};
    stim[9]  = '{ROM_BASE + 32'h00, 1'b0, 32'h0, 4'hF, 32'hB007_0000, 1'b1};
    stim[10] = '{ROM_BASE + 32'h14, 1'b0, 32'h0, 4'hF, 32'hB007_0005, 1'b1};
    stim[11] = '{ROM_BASE + 32'h50, 1'b0, 32'h0, 4'hF, 32'h0000_0000, 1'b1};
    stim[12] = '{ROM_BASE + 32'h14, 1'b1, 32'hDEAD_BEEF, 4'hF, 32'h0, 1'b0};
    stim[13] = '{ROM_BASE + 32'h14, 1'b0, 32'h0, 4'hF, 32'hB007_0005, 1'b1};
    stim[14] = '{PER_BASE + `REG_TCDM_START, 1'b0, 32'h0, 4'hF, 32'h0000_0000, 1'b1};
    stim[15] = '{PER_BASE + `REG_TCDM_END, 1'b0, 32'h0, 4'hF, 32'h0010_0000, 1'b1};
    stim[16] = '{PER_BASE + `REG_NUM_CORES, 1'b0, 32'h0, 4'hF, 32'h0000_0010, 1'b1};
    stim[17] = '{PER_BASE + `REG_EOC, 1'b1, 32'h0000_0001, 4'hF, 32'h0, 1'b0};
    stim[18] = '{PER_BASE + `REG_EOC, 1'b0, 32'h0, 4'hF, 32'h0000_0001, 1'b1};
    stim[19] = '{PER_BASE + `REG_WAKE_UP, 1'b1, 32'h0000_A5C3, 4'hF, 32'h0, 1'b0};
    stim[20] = '{L2_BASE + 32'h08, 1'b0, 32'h0, 4'hF, 32'h0, 1'b1};
    stim[21] = '{32'h2000_0010, 1'b0, 32'h0, 4'hF, 32'h0, 1'b1};
    stim[22] = '{32'h2000_0020, 1'b1, 32'h1234_5678, 4'hF, 32'h0, 1'b0};
    stim[23] = '{32'h2000_0030, 1'b0, 32'h0, 4'hF, 32'h0, 1'b1};
    stim[24] = '{PER_BASE + `REG_EOC, 1'b0, 32'h0, 4'hF, 32'h0000_0001, 1'b1};
  end

  initial begin
    int waited;
    host_req_i = '0;
    rst_n_i    = 1'b0;
    repeat (4) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;
    @(negedge clk_i);
    check_value("eoc_valid_o", eoc_valid_o, 1'b0);
    check_value("wake_up_o", wake_up_o, '0);
    check_value("host_rsp_o.rvalid", host_rsp_o.rvalid, 1'b0);
    check_value("mst_req_o.req", mst_req_o.req, 1'b0);
    @(posedge clk_i);
    #1;
    for (int r = 0; r < NUM_ROWS; r++) begin
      row_idx = r;
      apply_row(stim[r]);
    end
    host_req_i = '0;
    waited     = 0;
    while (pend_q.size() != 0) begin
      @(negedge clk_i);
      waited++;
      if (waited > TIMEOUT) report_failure("Responses still outstanding after the last request");
    end
    check_value("eoc_valid_o", eoc_valid_o, 1'b1);
    $display("Simulation PASSED");
    $finish;
  end

endmodule

// ==== common/mempool_consts.svh ====
/* MemPool system constants
   Widths, address map, L2 bank geometry and control register offsets */
`ifndef MEMPOOL_CONSTS_SVH
`define MEMPOOL_CONSTS_SVH

`define ADDR_WIDTH        32
`define DATA_WIDTH        32
`define BE_WIDTH          4
`define NUM_CORES         16

// L2 geometry, words interleaved over the banks
`define NUM_L2_BANKS      4
`define L2_BANK_WORDS     64
`define L2_BASE_ADDR      32'h8000_0000
`define L2_END_ADDR       (`L2_BASE_ADDR + `NUM_L2_BANKS * `L2_BANK_WORDS * `BE_WIDTH)

`define PERIPH_BASE_ADDR  32'h4000_0000
`define PERIPH_END_ADDR   32'h4002_0000
`define BOOTROM_BASE_ADDR 32'hA000_0000
`define BOOTROM_END_ADDR  32'hA001_0000
`define BOOTROM_WORDS     16
`define BOOTROM_TAG       32'hB007_0000

`define TCDM_BASE_ADDR    32'h0000_0000
`define TCDM_SIZE         32'h0010_0000

// Control register offsets inside the peripheral window
`define REG_EOC           16'h0000
`define REG_WAKE_UP       16'h0004
`define REG_TCDM_START    16'h0008
`define REG_TCDM_END      16'h000C
`define REG_NUM_CORES     16'h0010

`endif

// ==== common/mempool_pkg.sv ====
/* MemPool system package
   Request, response, target and address view types of the memory side */
`include "mempool_consts.svh"

package mempool_pkg;

  // Word request as seen on every port of the system
  typedef struct packed {
    logic                   req;
    logic                   we;
    logic [`ADDR_WIDTH-1:0] addr;
    logic [`DATA_WIDTH-1:0] wdata;
    logic [`BE_WIDTH-1:0]   be;
  } mem_req_t;

  typedef struct packed {
    logic                   rvalid;  // One pulse per accepted request
    logic [`DATA_WIDTH-1:0] rdata;
  } mem_rsp_t;

  typedef enum logic [1:0] {
    TGT_L2,
    TGT_BOOTROM,
    TGT_PERIPH,
    TGT_EXTERNAL  // Also taken by unmapped addresses
  } soc_target_e;

  // Bank index sits right above the byte offset
  typedef struct packed {
    logic [`ADDR_WIDTH-$clog2(`L2_BANK_WORDS)-$clog2(`NUM_L2_BANKS)-$clog2(`BE_WIDTH)-1:0] upper;
    logic [$clog2(`L2_BANK_WORDS)-1:0] row;
    logic [$clog2(`NUM_L2_BANKS)-1:0]  bank;
    logic [$clog2(`BE_WIDTH)-1:0]      byte_off;
  } l2_addr_t;

  typedef struct packed {
    logic [`ADDR_WIDTH-17:0] upper;
    logic [15:0]             reg_off;
  } periph_addr_t;

  // Same address word, decoded by the L2 or by the register file
  typedef union packed {
    l2_addr_t     l2;
    periph_addr_t periph;
  } mem_addr_u;

endpackage

// ==== files.f ====
+incdir+common
common/mempool_pkg.sv
hdl/soc_demux.sv
l2/l2_memory.sv
hdl/bootrom.sv
hdl/ctrl_registers.sv
hdl/mempool_system.sv
bench/tb_mempool_system.sv

// ==== hdl/bootrom.sv ====
/* Boot ROM
   Fixed boot table, word addressed, registered one-cycle response */
`timescale 1ns/1ps
`include "mempool_consts.svh"

module bootrom
  import mempool_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  mem_req_t req_i,
  output mem_rsp_t rsp_o
);

  localparam int IDX_BITS = $clog2(`BOOTROM_WORDS);

  logic [`DATA_WIDTH-1:0] rom_table [`BOOTROM_WORDS];
  logic [`ADDR_WIDTH-1:0] word_idx;
  logic [`DATA_WIDTH-1:0] rdata_q;
  logic                   rvalid_q;

  // Word i carries the boot tag with its index in the low bits
  for (genvar i = 0; i < `BOOTROM_WORDS; i++) begin : gen_table
    assign rom_table[i] = `BOOTROM_TAG | `DATA_WIDTH'(i);
  end

  assign word_idx = (req_i.addr - `BOOTROM_BASE_ADDR) >> 2;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= req_i.req;  // Writes get an answer too
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i.req && !req_i.we) begin
      rdata_q <= (word_idx < `BOOTROM_WORDS) ? rom_table[word_idx[IDX_BITS-1:0]] : '0;
    end
  end

  assign rsp_o.rvalid = rvalid_q;
  assign rsp_o.rdata  = rdata_q;

endmodule

// ==== hdl/ctrl_registers.sv ====
/* Control registers
   End-of-computation flag, core wake-up pulses and read-only system info */
`timescale 1ns/1ps
`include "mempool_consts.svh"

module ctrl_registers
  import mempool_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  mem_req_t              req_i,
  output mem_rsp_t              rsp_o,
  output logic                  eoc_valid_o,
  output logic [`NUM_CORES-1:0] wake_up_o
);

  mem_addr_u              addr_u;
  logic                   wr_en;
  logic [`DATA_WIDTH-1:0] eoc_q;
  logic [`DATA_WIDTH-1:0] rdata_d;
  logic [`DATA_WIDTH-1:0] rdata_q;
  logic                   rvalid_q;

  assign addr_u = req_i.addr;
  assign wr_en  = req_i.req && req_i.we;

  // Read mux, upper address bits alias onto the same registers
  always_comb begin
    case (addr_u.periph.reg_off)
      `REG_EOC:        rdata_d = eoc_q;
      `REG_TCDM_START: rdata_d = `TCDM_BASE_ADDR;
      `REG_TCDM_END:   rdata_d = `TCDM_BASE_ADDR + `TCDM_SIZE;
      `REG_NUM_CORES:  rdata_d = `DATA_WIDTH'(`NUM_CORES);
      default:         rdata_d = '0;  // WAKE_UP is write-only
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      eoc_q     <= '0;
      wake_up_o <= '0;
      rvalid_q  <= 1'b0;
    end else begin
      rvalid_q  <= req_i.req;
      wake_up_o <= '0;  // Single-cycle pulse
      if (wr_en && addr_u.periph.reg_off == `REG_EOC) begin
        for (int i = 0; i < `BE_WIDTH; i++) begin
          if (req_i.be[i]) eoc_q[i*8 +: 8] <= req_i.wdata[i*8 +: 8];
        end
      end
      if (wr_en && addr_u.periph.reg_off == `REG_WAKE_UP) begin
        wake_up_o <= req_i.wdata[`NUM_CORES-1:0];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i.req) rdata_q <= rdata_d;
  end

  assign eoc_valid_o  = eoc_q[0];
  assign rsp_o.rvalid = rvalid_q;
  assign rsp_o.rdata  = rdata_q;

endmodule

// ==== hdl/mempool_system.sv ====
/* MemPool system top, memory side
   Host port routed to L2, boot ROM, control registers or the external master */
`timescale 1ns/1ps
`include "mempool_consts.svh"

module mempool_system
  import mempool_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  mem_req_t              host_req_i,
  output logic                  host_gnt_o,
  output mem_rsp_t              host_rsp_o,
  output mem_req_t              mst_req_o,
  input  logic                  mst_gnt_i,
  input  mem_rsp_t              mst_rsp_i,
  output logic                  eoc_valid_o,
  output logic [`NUM_CORES-1:0] wake_up_o
);

  mem_req_t l2_req;
  mem_rsp_t l2_rsp;
  mem_req_t rom_req;
  mem_rsp_t rom_rsp;
  mem_req_t periph_req;
  mem_rsp_t periph_rsp;

  soc_demux soc_demux_inst (
    .clk_i       (clk_i     ),
    .rst_n_i     (rst_n_i   ),
    .host_req_i  (host_req_i),
    .host_gnt_o  (host_gnt_o),
    .host_rsp_o  (host_rsp_o),
    .l2_req_o    (l2_req    ),
    .l2_rsp_i    (l2_rsp    ),
    .rom_req_o   (rom_req   ),
    .rom_rsp_i   (rom_rsp   ),
    .periph_req_o(periph_req),
    .periph_rsp_i(periph_rsp),
    .mst_req_o   (mst_req_o ),
    .mst_gnt_i   (mst_gnt_i ),
    .mst_rsp_i   (mst_rsp_i )
  );

  l2_memory l2_memory_inst (
    .clk_i  (clk_i  ),
    .rst_n_i(rst_n_i),
    .req_i  (l2_req ),
    .rsp_o  (l2_rsp )
  );

  bootrom bootrom_inst (
    .clk_i  (clk_i  ),
    .rst_n_i(rst_n_i),
    .req_i  (rom_req),
    .rsp_o  (rom_rsp)
  );

  // Serves the whole peripheral window
  ctrl_registers ctrl_registers_inst (
    .clk_i      (clk_i      ),
    .rst_n_i    (rst_n_i    ),
    .req_i      (periph_req ),
    .rsp_o      (periph_rsp ),
    .eoc_valid_o(eoc_valid_o),
    .wake_up_o  (wake_up_o  )
  );

endmodule

// ==== hdl/soc_demux.sv ====
/* System demux
   Decodes the host address, routes the request and steers the response back */
`timescale 1ns/1ps
`include "mempool_consts.svh"

module soc_demux
  import mempool_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  mem_req_t host_req_i,
  output logic     host_gnt_o,
  output mem_rsp_t host_rsp_o,
  output mem_req_t l2_req_o,
  input  mem_rsp_t l2_rsp_i,
  output mem_req_t rom_req_o,
  input  mem_rsp_t rom_rsp_i,
  output mem_req_t periph_req_o,
  input  mem_rsp_t periph_rsp_i,
  output mem_req_t mst_req_o,
  input  logic     mst_gnt_i,
  input  mem_rsp_t mst_rsp_i
);

  soc_target_e tgt;            // Decoded target of the host request
  soc_target_e tgt_q;          // Target of the last accepted request
  logic        accept;
  logic        int_pending_q;  // Internal response returns this cycle
  logic        ext_wait_q;     // External request granted, response outstanding

  always_comb begin
    if (host_req_i.addr >= `L2_BASE_ADDR && host_req_i.addr < `L2_END_ADDR) begin
      tgt = TGT_L2;
    end else if (host_req_i.addr >= `PERIPH_BASE_ADDR && host_req_i.addr < `PERIPH_END_ADDR) begin
      tgt = TGT_PERIPH;
    end else if (host_req_i.addr >= `BOOTROM_BASE_ADDR &&
                 host_req_i.addr < `BOOTROM_END_ADDR) begin
      tgt = TGT_BOOTROM;
    end else begin
      tgt = TGT_EXTERNAL;
    end
  end

  // External port sees the request only once internal responses have drained
  always_comb begin
    mst_req_o     = host_req_i;
    mst_req_o.req = host_req_i.req && (tgt == TGT_EXTERNAL) && !ext_wait_q && !int_pending_q;
  end

  always_comb begin
    if (ext_wait_q) begin
      host_gnt_o = 1'b0;  // Hold everything until the external response
    end else if (tgt == TGT_EXTERNAL) begin
      host_gnt_o = mst_gnt_i && !int_pending_q;
    end else begin
      host_gnt_o = 1'b1;
    end
  end

  assign accept = host_req_i.req && host_gnt_o;

  always_comb begin
    l2_req_o         = host_req_i;
    rom_req_o        = host_req_i;
    periph_req_o     = host_req_i;
    l2_req_o.req     = accept && (tgt == TGT_L2);
    rom_req_o.req    = accept && (tgt == TGT_BOOTROM);
    periph_req_o.req = accept && (tgt == TGT_PERIPH);
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      tgt_q         <= TGT_L2;
      int_pending_q <= 1'b0;
      ext_wait_q    <= 1'b0;
    end else begin
      int_pending_q <= accept && (tgt != TGT_EXTERNAL);
      if (accept) tgt_q <= tgt;
      if (accept && tgt == TGT_EXTERNAL) begin
        ext_wait_q <= 1'b1;
      end else if (mst_rsp_i.rvalid) begin
        ext_wait_q <= 1'b0;
      end
    end
  end

  // Responses come back in accept order, so the last tag picks the source
  always_comb begin
    case (tgt_q)
      TGT_L2:      host_rsp_o = l2_rsp_i;
      TGT_BOOTROM: host_rsp_o = rom_rsp_i;
      TGT_PERIPH:  host_rsp_o = periph_rsp_i;
      default: begin
        host_rsp_o        = mst_rsp_i;
        host_rsp_o.rvalid = mst_rsp_i.rvalid && ext_wait_q;
      end
    endcase
  end

endmodule

// ==== l2/l2_memory.sv ====
/* L2 memory
   Word-interleaved banks with byte-enable writes and a one-cycle response */
`timescale 1ns/1ps
`include "mempool_consts.svh"

module l2_memory
  import mempool_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  mem_req_t req_i,
  output mem_rsp_t rsp_o
);

  localparam int BANK_BITS = $clog2(`NUM_L2_BANKS);

  mem_addr_u              addr_u;
  logic [BANK_BITS-1:0]   bank_q;     // Bank that answers next cycle
  logic                   rvalid_q;
  logic [`DATA_WIDTH-1:0] bank_rdata [`NUM_L2_BANKS];

  assign addr_u = req_i.addr;

  for (genvar b = 0; b < `NUM_L2_BANKS; b++) begin : gen_banks
    logic [`DATA_WIDTH-1:0] mem_q [`L2_BANK_WORDS];
    logic [`DATA_WIDTH-1:0] rdata_q;
    logic                   bank_req;

    assign bank_req      = req_i.req && (addr_u.l2.bank == BANK_BITS'(b));
    assign bank_rdata[b] = rdata_q;

    always_ff @(posedge clk_i) begin
      if (bank_req) begin
        if (req_i.we) begin
          for (int i = 0; i < `BE_WIDTH; i++) begin
            if (req_i.be[i]) mem_q[addr_u.l2.row][i*8 +: 8] <= req_i.wdata[i*8 +: 8];
          end
        end
        rdata_q <= mem_q[addr_u.l2.row];  // Old word, read-first
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= req_i.req;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i.req) bank_q <= addr_u.l2.bank;
  end

  assign rsp_o.rvalid = rvalid_q;
  assign rsp_o.rdata  = bank_rdata[bank_q];

endmodule
